/* bench/rename_top_golden.txt */
# u op use_imm rs1 src2 rd pdst pdst_old psrc1 psrc2 imm src1_ready src2_ready (decimal)
# w n wakes preg n, b n wakes preg n in the next micro-op's lookup cycle, f n frees preg n
# s n turns random out_ready stalls on or off, e n expects in_ready low for n cycles
u 1 0 1 2 3 32 3 1 2 0 1 1
u 2 0 3 4 5 33 5 32 4 0 0 1
u 3 1 5 17 3 34 32 33 0 17 0 1
w 33
u 4 0 5 3 7 35 7 33 34 0 1 0
b 34
u 5 0 3 7 8 36 8 34 35 0 1 0
u 6 1 8 31 5 37 33 36 0 31 0 1
u 7 0 3 0 9 38 9 34 0 0 1 1
s 1
u 8 0 9 7 10 39 10 38 35 0 0 0
u 9 1 10 5 11 40 11 39 0 5 0 1
u 10 0 1 2 12 41 12 1 2 0 1 1
u 11 0 12 11 12 42 41 41 40 0 0 0
u 12 0 4 5 13 43 13 4 37 0 1 0
u 13 0 13 14 14 44 14 43 14 0 0 1
u 14 1 14 1 15 45 15 44 0 1 0 1
u 15 0 0 15 16 46 16 0 45 0 1 0
u 0 0 16 17 17 47 17 46 17 0 0 1
u 1 1 17 2 18 48 18 47 0 2 0 1
u 2 0 18 19 19 49 19 48 19 0 0 1
u 3 0 20 19 20 50 20 20 49 0 1 0
u 4 1 20 3 21 51 21 50 0 3 0 1
u 5 0 21 22 22 52 22 51 22 0 0 1
u 6 0 22 22 23 53 23 52 52 0 0 0
u 7 1 23 4 24 54 24 53 0 4 0 1
u 8 0 24 25 25 55 25 54 25 0 0 1
u 9 0 26 25 26 56 26 26 55 0 1 0
u 10 1 26 6 27 57 27 56 0 6 0 1
u 11 0 27 28 28 58 28 57 28 0 0 1
u 12 0 28 29 29 59 29 58 29 0 0 1
u 13 1 29 7 30 60 30 59 0 7 0 1
u 14 0 30 31 31 61 31 60 31 0 0 1
u 15 0 31 6 3 62 34 61 6 0 0 1
u 0 1 3 8 5 63 37 62 0 8 0 1
e 4
s 0
f 32
u 1 0 3 5 7 32 35 62 63 0 0 0

/* bench/rename_top_props.sv */
`timescale 1ns/1ns

module rename_top_props (
    input logic                             clk,
    input logic                             rst,
    input logic                             in_ready,
    input logic                             out_valid,
    input logic                             out_ready,
    input logic [rename_pkg::op_bits-1:0]   out_op,
    input logic [rename_pkg::preg_bits-1:0] out_psrc1,
    input logic [rename_pkg::preg_bits-1:0] out_psrc2,
    input logic [rename_pkg::imm_bits-1:0]  out_imm,
    input logic [rename_pkg::preg_bits-1:0] out_pdst,
    input logic [rename_pkg::preg_bits-1:0] out_pdst_old
);

    int fail_cnt = 0;  // read by the testbench

    reset_quiet: assert property (@(posedge clk) $fell(rst) |-> !out_valid && !in_ready)
        else begin
            fail_cnt++;
            $error("out_valid or in_ready high on the first edge out of reset");
        end

    // ready bits may still rise while held, the rest of the micro-op may not change
    hold_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid
            && $stable({out_op, out_psrc1, out_psrc2, out_imm, out_pdst, out_pdst_old}))
        else begin
            fail_cnt++;
            $error("held output micro-op changed or dropped under back-pressure");
        end

    fresh_dest: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_pdst != out_pdst_old)
        else begin
            fail_cnt++;
            $error("out_pdst equals out_pdst_old");
        end

endmodule

bind rename_top rename_top_props props_i (.*);

/* bench/rename_top_tb.sv */
`timescale 1ns/1ns

module rename_top_tb;

    localparam int max_wait = 400;

    logic                             clk = 1'b0;
    logic                             rst;
    logic                             in_valid;
    logic [rename_pkg::op_bits-1:0]   in_op;
    logic                             in_use_imm;
    logic [rename_pkg::areg_bits-1:0] in_rs1;
    logic [rename_pkg::areg_bits-1:0] in_src2;
    logic [rename_pkg::areg_bits-1:0] in_rd;
    logic                             in_ready;
    logic                             wb_en;
    logic [rename_pkg::preg_bits-1:0] wb_preg;
    logic                             free_en;
    logic [rename_pkg::preg_bits-1:0] free_preg;
    logic                             out_valid;
    logic [rename_pkg::op_bits-1:0]   out_op;
    logic                             out_use_imm;
    logic [rename_pkg::preg_bits-1:0] out_psrc1;
    logic [rename_pkg::preg_bits-1:0] out_psrc2;
    logic [rename_pkg::imm_bits-1:0]  out_imm;
    logic [rename_pkg::preg_bits-1:0] out_pdst;
    logic [rename_pkg::preg_bits-1:0] out_pdst_old;
    logic                             out_src1_ready;
    logic                             out_src2_ready;
    logic                             out_ready;

    logic                             stall_mode = 1'b0;  // random out_ready gaps when set
    int                               cyc = 0;
    int                               fld [12];          // columns of the current u line
    logic                             bypass_pending = 1'b0;
    logic [rename_pkg::preg_bits-1:0] bypass_preg;

    rename_pkg::renamed_uop_t exp_uop_q [$];
    logic                     exp_r1_q [$];
    logic                     exp_r2_q [$];
    int                       exp_cyc_q [$];
    logic                     exp_lat_q [$];
    int                       exp_line_q [$];

    rename_top rename_top_i (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic stop_with(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_preg(input string name, input logic [rename_pkg::preg_bits-1:0] exp,
                              input logic [rename_pkg::preg_bits-1:0] act);
        if (act !== exp) begin
            stop_with($sformatf("error %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with($sformatf("error %s expected %0b actual %0b", name, exp, act));
        end
    endtask

    task automatic check_imm(input string name, input logic [rename_pkg::imm_bits-1:0] exp,
                             input logic [rename_pkg::imm_bits-1:0] act);
        if (act !== exp) begin
            stop_with($sformatf("error %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_op(input string name, input logic [rename_pkg::op_bits-1:0] exp,
                            input logic [rename_pkg::op_bits-1:0] act);
        if (act !== exp) begin
            stop_with($sformatf("error %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic compare_output();
        rename_pkg::renamed_uop_t exp;
        string                    name;
        int                       lat;
        if (exp_uop_q.size() == 0) begin
            stop_with("an output appeared with no micro-op left to match it");
        end else begin
            exp  = exp_uop_q.pop_front();
            name = $sformatf("line %0d", exp_line_q.pop_front());
            lat  = cyc - exp_cyc_q.pop_front();
            if (exp_lat_q.pop_front() && lat != 2) begin
                stop_with($sformatf("error %s latency expected 2 actual %0d", name, lat));
            end
            check_op({name, " op"}, exp.op, out_op);
            check_ready({name, " use_imm"}, exp.use_imm, out_use_imm);
            check_preg({name, " psrc1"}, exp.psrc1, out_psrc1);
            check_preg({name, " psrc2"}, exp.psrc2, out_psrc2);
            check_imm({name, " imm"}, exp.imm, out_imm);
            check_preg({name, " pdst"}, exp.pdst, out_pdst);
            check_preg({name, " pdst_old"}, exp.pdst_old, out_pdst_old);
            check_ready({name, " src1_ready"}, exp_r1_q.pop_front(), out_src1_ready);
            check_ready({name, " src2_ready"}, exp_r2_q.pop_front(), out_src2_ready);
        end
    endtask

    // starts and ends 2 ns after a rising edge
    task automatic send_uop(input int line_no);
        rename_pkg::renamed_uop_t exp;
        int                       waited;
        in_valid   = 1'b1;
        in_op      = fld[0];
        in_use_imm = fld[1];
        in_rs1     = fld[2];
        in_src2    = fld[3];
        in_rd      = fld[4];
        exp.op       = fld[0];
        exp.use_imm  = fld[1];
        exp.pdst     = fld[5];
        exp.pdst_old = fld[6];
        exp.psrc1    = fld[7];
        exp.psrc2    = fld[8];
        exp.imm      = fld[9];
        waited = 0;
        @(negedge clk);
        while (!in_ready) begin
            waited++;
            if (waited > max_wait) begin
                stop_with($sformatf("line %0d was never accepted, in_ready stayed low", line_no));
            end
            @(negedge clk);
        end
        exp_uop_q.push_back(exp);
        exp_r1_q.push_back(fld[10] != 0);
        exp_r2_q.push_back(fld[11] != 0);
        exp_cyc_q.push_back(cyc);
        exp_lat_q.push_back(!stall_mode);
        exp_line_q.push_back(line_no);
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        if (bypass_pending) begin
            wb_en          = 1'b1;  // lands in the cycle this micro-op looks up its sources
            wb_preg        = bypass_preg;
            bypass_pending = 1'b0;
            @(posedge clk);
            #2;
            wb_en = 1'b0;
        end
    endtask

    task automatic pulse_wakeup(input int preg);
        wb_en   = 1'b1;
        wb_preg = preg;
        @(posedge clk);
        #2;
        wb_en = 1'b0;
    endtask

    task automatic pulse_free(input int preg);
        free_en   = 1'b1;
        free_preg = preg;
        @(posedge clk);
        #2;
        free_en = 1'b0;
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (exp_uop_q.size() != 0) begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > max_wait) begin
                stop_with("pending micro-ops never left the pipeline");
            end
        end
    endtask

    task automatic check_stalled_input(input int cycles, input int line_no);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_ready($sformatf("line %0d in_ready", line_no), 1'b0, in_ready);
        end
        @(posedge clk);
        #2;
    endtask

    // output consumer with an optional random stall pattern
    initial begin
        void'($urandom(32'ha40ab704));
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (stall_mode) begin
                out_ready = ($urandom % 3) != 0;
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (rename_top_i.props_i.fail_cnt != 0) begin
            stop_with("a bound assertion on rename_top failed");
        end else if (!rst && out_valid && out_ready) begin
            compare_output();
        end
    end

    initial begin
        int    fd;
        int    line_no;
        int    n;
        int    val;
        string line;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_op      = '0;
        in_use_imm = 1'b0;
        in_rs1     = '0;
        in_src2    = '0;
        in_rd      = '0;
        wb_en      = 1'b0;
        wb_preg    = '0;
        free_en    = 1'b0;
        free_preg  = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        fd = $fopen("bench/rename_top_golden.txt", "r");
        if (fd == 0) begin
            stop_with("could not open bench/rename_top_golden.txt");
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            if (n == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            val = 0;
            n = $sscanf(line.substr(1, line.len() - 1), "%d", val);
            case (line[0])
                "u": begin
                    n = $sscanf(line, "u %d %d %d %d %d %d %d %d %d %d %d %d",
                                fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                                fld[6], fld[7], fld[8], fld[9], fld[10], fld[11]);
                    if (n != 12) begin
                        stop_with($sformatf("line %0d of the golden file is malformed", line_no));
                    end
                    send_uop(line_no);
                end
                "w": begin
                    drain_outputs();  // nothing in flight, so ready bits stay predictable
                    pulse_wakeup(val);
                end
                "b": begin
                    bypass_pending = 1'b1;
                    bypass_preg    = val;
                end
                "f": pulse_free(val);
                "e": begin
                    drain_outputs();
                    check_stalled_input(val, line_no);
                end
                "s": begin
                    drain_outputs();
                    stall_mode <= (val != 0);
                end
                default: stop_with($sformatf("line %0d has an unknown directive", line_no));
            endcase
        end
        $fclose(fd);
        drain_outputs();
        repeat (4) @(posedge clk);
        if (rename_top_i.props_i.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stop_with("a bound assertion on rename_top failed");
        end
    end

endmodule

/* hw/busy_table.sv */
`timescale 1ns/1ns

module busy_table (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             alloc_en,
    input  logic [rename_pkg::preg_bits-1:0] alloc_preg,
    input  logic                             wb_en,
    input  logic [rename_pkg::preg_bits-1:0] wb_preg,
    input  logic [rename_pkg::preg_bits-1:0] look_preg1,
    input  logic [rename_pkg::preg_bits-1:0] look_preg2,
    output logic                             look_ready1,
    output logic                             look_ready2
);

    logic [rename_pkg::preg_count-1:0] busy;
    logic [rename_pkg::preg_count-1:0] wake_vec;
    logic [rename_pkg::preg_count-1:0] alloc_vec;
    logic [rename_pkg::preg_count-1:0] avail;

    // one-hot decode of the wakeup and allocation targets
    always_comb begin
        wake_vec  = '0;
        alloc_vec = '0;
        if (wb_en) begin
            wake_vec[wb_preg] = 1'b1;
        end
        if (alloc_en) begin
            alloc_vec[alloc_preg] = 1'b1;
        end
    end

    // a wakeup in the lookup cycle counts as already written back
    assign avail = ~busy | wake_vec;

    assign look_ready1 = avail[look_preg1];
    assign look_ready2 = avail[look_preg2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= '0;
        end else begin
            busy <= (busy & ~wake_vec) | alloc_vec;  // set wins over clear
        end
    end

endmodule

/* hw/operand_ready_stage.sv */
`timescale 1ns/1ns

module operand_ready_stage (
    input  logic                              clk,
    input  logic                              rst,
    stage_if.consumer                         up,
    output logic [rename_pkg::preg_bits-1:0]  look_preg1,
    output logic [rename_pkg::preg_bits-1:0]  look_preg2,
    input  logic                              look_ready1,
    input  logic                              look_ready2,
    output logic                              out_valid,
    output rename_pkg::renamed_uop_t          out_uop,
    output logic                              out_src1_ready,
    output logic                              out_src2_ready,
    input  logic                              out_ready
);

    logic take;
    logic hold;

    assign hold    = out_valid && !out_ready;
    assign up.ready = !out_valid || out_ready;
    assign take    = up.valid && up.ready;

    // while stalled the lookups follow the held micro-op so late wakeups are seen
    assign look_preg1 = hold ? out_uop.psrc1 : up.uop.psrc1;
    assign look_preg2 = hold ? out_uop.psrc2 : up.uop.psrc2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_uop        <= up.uop;
            out_src1_ready <= look_ready1;
            out_src2_ready <= up.uop.use_imm || look_ready2;  // an immediate needs no producer
        end else if (hold) begin
            // ready bits only ever rise while the micro-op waits here
            out_src1_ready <= out_src1_ready || look_ready1;
            out_src2_ready <= out_src2_ready || look_ready2;
        end
    end

endmodule

/* hw/rename_pkg.sv */
package rename_pkg;

    localparam int areg_bits = 5;
    localparam int areg_count = 32;
    localparam int preg_bits = 6;
    localparam int preg_count = 64;
    localparam int op_bits = 4;
    localparam int imm_bits = 5;

    // registers above the identity mapping start out on the free list
    localparam int free_depth = preg_count - areg_count;
    localparam int free_ptr_bits = $clog2(free_depth);

    // second operand field, read as a register index or as an immediate
    typedef union packed {
        logic [areg_bits-1:0] reg_form;  // architectural rs2
        logic [imm_bits-1:0]  imm_form;  // unsigned immediate
    } src2_word_t;

    typedef struct packed {
        logic [op_bits-1:0]   op;
        logic                 use_imm;  // selects the imm_form reading of src2
        logic [areg_bits-1:0] rs1;
        src2_word_t           src2;
        logic [areg_bits-1:0] rd;
    } uop_t;

    typedef struct packed {
        logic [op_bits-1:0]   op;
        logic                 use_imm;
        logic [preg_bits-1:0] psrc1;
        logic [preg_bits-1:0] psrc2;     // zero for the immediate form
        logic [imm_bits-1:0]  imm;       // zero for the register form
        logic [preg_bits-1:0] pdst;
        logic [preg_bits-1:0] pdst_old;  // released by commit once rd is overwritten
    } renamed_uop_t;

endpackage

/* hw/rename_stage.sv */
`timescale 1ns/1ns

module rename_stage (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               in_valid,
    input  rename_pkg::uop_t                   in_uop,
    output logic                               in_ready,
    input  logic                               free_en,
    input  logic [rename_pkg::preg_bits-1:0]   free_preg,
    output logic                               alloc_en,
    output logic [rename_pkg::preg_bits-1:0]   alloc_preg,
    stage_if.producer                          down
);

    logic [rename_pkg::preg_bits-1:0]     map_table [rename_pkg::areg_count];
    logic [rename_pkg::preg_bits-1:0]     free_mem [rename_pkg::free_depth];
    logic [rename_pkg::free_ptr_bits-1:0] pop_ptr;
    logic [rename_pkg::free_ptr_bits-1:0] push_ptr;
    logic [rename_pkg::free_ptr_bits:0]   free_cnt;

    logic                                 run;  // low in reset and the cycle after
    logic                                 stage_valid;
    rename_pkg::renamed_uop_t             stage_uop;
    rename_pkg::renamed_uop_t             next_uop;

    logic                                 accept;
    logic                                 push;
    logic                                 free_empty;
    logic                                 free_full;

    assign free_empty = (free_cnt == 0);
    assign free_full  = (free_cnt == rename_pkg::free_depth);

    assign in_ready = run && (!stage_valid || down.ready) && !free_empty;
    assign accept   = in_valid && in_ready;
    assign push     = free_en && !free_full;  // a free into a full list has nowhere to go

    assign alloc_en   = accept;
    assign alloc_preg = free_mem[pop_ptr];

    // sources read the mapping before this micro-op's own rd update lands
    always_comb begin
        next_uop.op       = in_uop.op;
        next_uop.use_imm  = in_uop.use_imm;
        next_uop.psrc1    = map_table[in_uop.rs1];
        next_uop.pdst     = free_mem[pop_ptr];
        next_uop.pdst_old = map_table[in_uop.rd];
        if (in_uop.use_imm) begin
            next_uop.psrc2 = '0;
            next_uop.imm   = in_uop.src2.imm_form;
        end else begin
            next_uop.psrc2 = map_table[in_uop.src2.reg_form];
            next_uop.imm   = '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::areg_count; i++) begin
                map_table[i] <= (rename_pkg::preg_bits)'(i);  // identity mapping
            end
        end else if (accept) begin
            map_table[in_uop.rd] <= free_mem[pop_ptr];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::free_depth; i++) begin
                free_mem[i] <= (rename_pkg::preg_bits)'(rename_pkg::areg_count + i);
            end
            pop_ptr  <= '0;
            push_ptr <= '0;  // list starts full, so the tail wraps onto the head
            free_cnt <= (rename_pkg::free_ptr_bits + 1)'(rename_pkg::free_depth);
        end else begin
            if (push) begin
                free_mem[push_ptr] <= free_preg;
                push_ptr           <= push_ptr + 1'b1;
            end
            if (accept) begin
                pop_ptr <= pop_ptr + 1'b1;
            end
            case ({push, accept})
                2'b10:   free_cnt <= free_cnt + 1'b1;
                2'b01:   free_cnt <= free_cnt - 1'b1;
                default: free_cnt <= free_cnt;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else if (accept) begin
            stage_valid <= 1'b1;
        end else if (down.ready) begin
            stage_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage_uop <= next_uop;
        end
    end

    assign down.valid = stage_valid;
    assign down.uop   = stage_uop;

endmodule

/* hw/rename_top.sv */
`timescale 1ns/1ns

module rename_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             in_valid,
    input  logic [rename_pkg::op_bits-1:0]   in_op,
    input  logic                             in_use_imm,
    input  logic [rename_pkg::areg_bits-1:0] in_rs1,
    input  logic [rename_pkg::areg_bits-1:0] in_src2,
    input  logic [rename_pkg::areg_bits-1:0] in_rd,
    output logic                             in_ready,
    input  logic                             wb_en,
    input  logic [rename_pkg::preg_bits-1:0] wb_preg,
    input  logic                             free_en,
    input  logic [rename_pkg::preg_bits-1:0] free_preg,
    output logic                             out_valid,
    output logic [rename_pkg::op_bits-1:0]   out_op,
    output logic                             out_use_imm,
    output logic [rename_pkg::preg_bits-1:0] out_psrc1,
    output logic [rename_pkg::preg_bits-1:0] out_psrc2,
    output logic [rename_pkg::imm_bits-1:0]  out_imm,
    output logic [rename_pkg::preg_bits-1:0] out_pdst,
    output logic [rename_pkg::preg_bits-1:0] out_pdst_old,
    output logic                             out_src1_ready,
    output logic                             out_src2_ready,
    input  logic                             out_ready
);

    rename_pkg::uop_t                 in_uop;
    rename_pkg::renamed_uop_t         out_uop;
    logic                             alloc_en;
    logic [rename_pkg::preg_bits-1:0] alloc_preg;
    logic [rename_pkg::preg_bits-1:0] look_preg1;
    logic [rename_pkg::preg_bits-1:0] look_preg2;
    logic                             look_ready1;
    logic                             look_ready2;

    stage_if stage_link ();

    always_comb begin
        in_uop.op      = in_op;
        in_uop.use_imm = in_use_imm;
        in_uop.rs1     = in_rs1;
        in_uop.src2    = in_src2;  // raw field, decoded later by use_imm
        in_uop.rd      = in_rd;
    end

    rename_stage rename_stage_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_uop     (in_uop),
        .in_ready   (in_ready),
        .free_en    (free_en),
        .free_preg  (free_preg),
        .alloc_en   (alloc_en),
        .alloc_preg (alloc_preg),
        .down       (stage_link.producer)
    );

    busy_table busy_table_i (
        .clk         (clk),
        .rst         (rst),
        .alloc_en    (alloc_en),
        .alloc_preg  (alloc_preg),
        .wb_en       (wb_en),
        .wb_preg     (wb_preg),
        .look_preg1  (look_preg1),
        .look_preg2  (look_preg2),
        .look_ready1 (look_ready1),
        .look_ready2 (look_ready2)
    );

    operand_ready_stage operand_ready_stage_i (
        .clk            (clk),
        .rst            (rst),
        .up             (stage_link.consumer),
        .look_preg1     (look_preg1),
        .look_preg2     (look_preg2),
        .look_ready1    (look_ready1),
        .look_ready2    (look_ready2),
        .out_valid      (out_valid),
        .out_uop        (out_uop),
        .out_src1_ready (out_src1_ready),
        .out_src2_ready (out_src2_ready),
        .out_ready      (out_ready)
    );

    assign out_op       = out_uop.op;
    assign out_use_imm  = out_uop.use_imm;
    assign out_psrc1    = out_uop.psrc1;
    assign out_psrc2    = out_uop.psrc2;
    assign out_imm      = out_uop.imm;
    assign out_pdst     = out_uop.pdst;
    assign out_pdst_old = out_uop.pdst_old;

endmodule

/* hw/stage_if.sv */
`timescale 1ns/1ns

interface stage_if;

    logic                       valid;
    logic                       ready;
    rename_pkg::renamed_uop_t   uop;

    // rename side
    modport producer (
        output valid,
        output uop,
        input  ready
    );

    // operand-ready side
    modport consumer (
        input  valid,
        input  uop,
        output ready
    );

endinterface

/* rename_top.f */
hw/rename_pkg.sv
hw/stage_if.sv
hw/rename_stage.sv
hw/busy_table.sv
hw/operand_ready_stage.sv
hw/rename_top.sv
bench/rename_top_props.sv
bench/rename_top_tb.sv
